// ==== src/jrx_settings.svh ====
`ifndef JRX_SETTINGS_SVH
`define JRX_SETTINGS_SVH

// ************************************************************
// Link geometry
// ************************************************************
`define JRX_NUM_LANES 2
`define JRX_DPW 4          // Octets per beat

// ************************************************************
// Character codes and CGS thresholds
// ************************************************************
`define JRX_K28_5 8'hbc
`define JRX_CGS_K_BEATS 4
`define JRX_CGS_ERR_BEATS 3

// Elastic buffer and LMFC sizing
`define JRX_BUF_DEPTH 32
`define JRX_BUF_AW 5
`define JRX_LMFC_W 8

`endif

// ==== src/jrx_link_pkg.sv ====
`include "jrx_settings.svh"

package jrx_link_pkg;

  // One lane's worth of data per clock
  typedef logic [8*`JRX_DPW-1:0] beat_t;

  // LMFC phase, counted in beats
  typedef logic [`JRX_LMFC_W-1:0] lmfc_count_t;

  typedef logic [`JRX_NUM_LANES-1:0] lane_mask_t;

  // Both bits set means DATA
  typedef enum logic [1:0] {
    CTRL_RESET = 2'b00,
    CTRL_CGS   = 2'b01,
    CTRL_DATA  = 2'b11
  } ctrl_state_t;

  // One marker bit per output octet
  typedef logic [`JRX_DPW-1:0] mark_t;

endpackage

// ==== src/jrx_lane_pkg.sv ====
`include "jrx_settings.svh"

package jrx_lane_pkg;

  typedef logic [7:0] octet_t;

  // Per-octet PHY flags (charisk, notintable, disperr)
  typedef logic [`JRX_DPW-1:0] char_flags_t;

  typedef enum logic [1:0] {
    CGS_INIT  = 2'b00,
    CGS_CHECK = 2'b01,
    CGS_DATA  = 2'b10
  } cgs_state_t;

  typedef logic [`JRX_BUF_AW-1:0] buf_addr_t;

endpackage

// ==== src/jrx_lane.sv ====
`timescale 1ns/100ps
`include "jrx_settings.svh"

module jrx_lane (
  input  logic                     clk,
  input  logic                     i_device_reset,
  input  jrx_link_pkg::beat_t      i_phy_data,
  input  jrx_lane_pkg::char_flags_t i_phy_charisk,
  input  jrx_lane_pkg::char_flags_t i_phy_notintable,
  input  jrx_lane_pkg::char_flags_t i_phy_disperr,
  input  logic                     i_cgs_reset,
  input  logic                     i_buffer_release_n,
  output logic                     o_cgs_ready,
  output logic                     o_buffer_ready_n,
  output jrx_link_pkg::beat_t      o_rx_data,
  output jrx_lane_pkg::cgs_state_t o_cgs_state
);

  jrx_lane_pkg::cgs_state_t state;
  jrx_lane_pkg::octet_t     octet0;
  jrx_lane_pkg::buf_addr_t  wr_ptr;
  jrx_lane_pkg::buf_addr_t  rd_ptr;
  jrx_link_pkg::beat_t      mem [`JRX_BUF_DEPTH];
  logic [2:0]               k_cnt;
  logic [2:0]               err_cnt;
  logic                     all_k;
  logic                     err_beat;
  logic                     started;
  logic                     frame_start;
  logic                     wr_en;

  // ************************************************************
  // Character classification
  // ************************************************************
  assign octet0   = i_phy_data[7:0];
  assign err_beat = |(i_phy_notintable | i_phy_disperr);

  always_comb begin
    all_k = &i_phy_charisk && !err_beat;
    for (int j = 0; j < `JRX_DPW; j++) begin
      if (i_phy_data[8*j +: 8] != `JRX_K28_5)
        all_k = 1'b0;
    end
  end

  // ************************************************************
  // CGS state machine
  // ************************************************************
  always_ff @(posedge clk) begin
    if (i_device_reset || i_cgs_reset) begin
      state   <= jrx_lane_pkg::CGS_INIT;
      k_cnt   <= '0;
      err_cnt <= '0;
    end else begin
      case (state)
        jrx_lane_pkg::CGS_INIT: begin
          if (all_k) begin
            state <= jrx_lane_pkg::CGS_CHECK;
            k_cnt <= 3'd1;
          end
        end
        jrx_lane_pkg::CGS_CHECK: begin
          if (!all_k) begin
            state <= jrx_lane_pkg::CGS_INIT;
            k_cnt <= '0;
          end else if (k_cnt == 3'(`JRX_CGS_K_BEATS - 1)) begin
            state   <= jrx_lane_pkg::CGS_DATA;
            err_cnt <= '0;
          end else begin
            k_cnt <= k_cnt + 3'd1;
          end
        end
        jrx_lane_pkg::CGS_DATA: begin
          if (!err_beat) begin
            err_cnt <= '0;
          end else if (err_cnt == 3'(`JRX_CGS_ERR_BEATS - 1)) begin
            state <= jrx_lane_pkg::CGS_INIT; // Lock lost
            k_cnt <= '0;
          end else begin
            err_cnt <= err_cnt + 3'd1;
          end
        end
        default: state <= jrx_lane_pkg::CGS_INIT;
      endcase
    end
  end

  assign o_cgs_state = state;
  assign o_cgs_ready = (state == jrx_lane_pkg::CGS_DATA);

  // ************************************************************
  // Frame start and elastic buffer
  // ************************************************************
  assign frame_start = (state == jrx_lane_pkg::CGS_DATA) && !started &&
                       !(i_phy_charisk[0] && octet0 == `JRX_K28_5);
  assign wr_en = (state == jrx_lane_pkg::CGS_DATA) && (started || frame_start);

  always_ff @(posedge clk) begin
    if (i_device_reset || i_cgs_reset) begin
      started <= 1'b0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end else begin
      if (state != jrx_lane_pkg::CGS_DATA)
        started <= 1'b0;
      else if (frame_start)
        started <= 1'b1;
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (!i_buffer_release_n)
        rd_ptr <= rd_ptr + 1'b1;
      else if (!started)
        rd_ptr <= wr_ptr;      // Park on the slot the frame start goes to
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= i_phy_data;
    o_rx_data <= mem[rd_ptr];
  end

  assign o_buffer_ready_n = !started;

  // Buffer must not be overrun while waiting for release
  a_no_overflow: assert property (@(posedge clk) disable iff (i_device_reset || i_cgs_reset)
    (started && wr_en && i_buffer_release_n) |->
      (jrx_lane_pkg::buf_addr_t'(wr_ptr + 1'b1) != rd_ptr));

  // Lock needs an unbroken run of /K/ beats
  a_k_run: assert property (@(posedge clk) disable iff (i_device_reset || i_cgs_reset)
    $rose(o_cgs_ready) |-> $past(all_k, 1) && $past(all_k, 2) &&
                           $past(all_k, 3) && $past(all_k, 4));

endmodule

// ==== src/jrx_link_ctrl.sv ====
`timescale 1ns/100ps

module jrx_link_ctrl (
  input  logic                      clk,
  input  logic                      i_device_reset,
  input  jrx_link_pkg::lane_mask_t  i_cfg_lanes_disable,
  input  jrx_link_pkg::lane_mask_t  i_cgs_ready,
  input  logic                      i_lmfc_edge,
  output jrx_link_pkg::lane_mask_t  o_cgs_reset,
  output logic                      o_sync,
  output jrx_link_pkg::ctrl_state_t o_status_state,
  output logic                      o_event_unexpected_lane_state
);

  jrx_link_pkg::ctrl_state_t state;
  logic                      all_ready;
  logic                      lane_drop;

  assign all_ready = &(i_cgs_ready | i_cfg_lanes_disable);
  assign lane_drop = !all_ready;

  always_ff @(posedge clk) begin
    if (i_device_reset) begin
      state <= jrx_link_pkg::CTRL_RESET;
    end else begin
      case (state)
        jrx_link_pkg::CTRL_RESET: state <= jrx_link_pkg::CTRL_CGS;
        jrx_link_pkg::CTRL_CGS: begin
          if (i_lmfc_edge && all_ready)
            state <= jrx_link_pkg::CTRL_DATA;
        end
        jrx_link_pkg::CTRL_DATA: begin
          if (lane_drop)
            state <= jrx_link_pkg::CTRL_CGS; // Back to sync request
        end
        default: state <= jrx_link_pkg::CTRL_RESET;
      endcase
    end
  end

  // One dropout pulse as the link leaves DATA
  always_ff @(posedge clk) begin
    if (i_device_reset) begin
      o_event_unexpected_lane_state <= 1'b0;
    end else begin
      o_event_unexpected_lane_state <= (state == jrx_link_pkg::CTRL_DATA) && lane_drop;
    end
  end

  assign o_cgs_reset = (state == jrx_link_pkg::CTRL_RESET) ? '1 : i_cfg_lanes_disable;
  assign o_sync = (state == jrx_link_pkg::CTRL_DATA);
  assign o_status_state = state;

  // A lane held in CGS reset must not report ready
  a_reset_lane_idle: assert property (@(posedge clk) disable iff (i_device_reset)
    (i_cgs_ready & $past(o_cgs_reset)) == '0);

endmodule

// ==== src/jrx_lmfc.sv ====
`timescale 1ns/100ps

module jrx_lmfc (
  input  logic                      clk,
  input  logic                      i_device_reset,
  input  logic                      i_sysref,
  input  jrx_link_pkg::lmfc_count_t i_cfg_beats_per_multiframe,
  input  jrx_link_pkg::lmfc_count_t i_cfg_lmfc_offset,
  input  logic                      i_cfg_sysref_oneshot,
  output logic                      o_lmfc_edge,
  output jrx_link_pkg::lmfc_count_t o_lmfc_count,
  output logic                      o_sysref_edge,
  output logic                      o_sysref_alignment_error
);

  jrx_link_pkg::lmfc_count_t count;
  jrx_link_pkg::lmfc_count_t count_next;
  logic                      sysref_r;
  logic                      sysref_d;
  logic                      sysref_edge;
  logic                      aligned;

  assign sysref_edge = sysref_r && !sysref_d;
  assign count_next = (count >= i_cfg_beats_per_multiframe) ? '0 : count + 1'b1;

  // ************************************************************
  // Phase counter with SYSREF alignment
  // ************************************************************
  always_ff @(posedge clk) begin
    if (i_device_reset) begin
      sysref_r <= 1'b0;
      sysref_d <= 1'b0;
      aligned  <= 1'b0;
      count    <= '0;
      o_sysref_alignment_error <= 1'b0;
    end else begin
      sysref_r <= i_sysref;
      sysref_d <= sysref_r;
      o_sysref_alignment_error <= 1'b0;
      if (sysref_edge) begin
        aligned <= 1'b1;
        if (aligned && count_next != i_cfg_lmfc_offset)
          o_sysref_alignment_error <= 1'b1;  // Phase moved
        if (!aligned || !i_cfg_sysref_oneshot)
          count <= i_cfg_lmfc_offset;
        else
          count <= count_next;               // Oneshot, check only
      end else begin
        count <= count_next;
      end
    end
  end

  assign o_lmfc_count  = count;
  assign o_lmfc_edge   = (count == '0);
  assign o_sysref_edge = sysref_edge;

  a_count_range: assert property (@(posedge clk) disable iff (i_device_reset)
    o_lmfc_count <= i_cfg_beats_per_multiframe);

endmodule

// ==== src/jrx_release_framer.sv ====
`timescale 1ns/100ps
`include "jrx_settings.svh"

module jrx_release_framer (
  input  logic                      clk,
  input  logic                      i_device_reset,
  input  jrx_link_pkg::lmfc_count_t i_lmfc_count,
  input  jrx_link_pkg::lmfc_count_t i_cfg_buffer_delay,
  input  logic                      i_cfg_buffer_early_release,
  input  jrx_link_pkg::lane_mask_t  i_cfg_lanes_disable,
  input  jrx_link_pkg::lane_mask_t  i_buffer_ready_n,
  input  logic [2:0]                i_cfg_octets_per_frame,
  input  jrx_link_pkg::lmfc_count_t i_cfg_beats_per_multiframe,
  output logic                      o_buffer_release_n,
  output logic                      o_rx_valid,
  output jrx_link_pkg::mark_t       o_rx_sof,
  output jrx_link_pkg::mark_t       o_rx_eof,
  output jrx_link_pkg::mark_t       o_rx_somf,
  output jrx_link_pkg::mark_t       o_rx_eomf
);

  jrx_link_pkg::lmfc_count_t mf_beat;
  jrx_link_pkg::mark_t       sof_s;
  jrx_link_pkg::mark_t       eof_s;
  logic [2:0]                frame_pos;
  logic [2:0]                pos;
  logic                      release_slot;

  // ************************************************************
  // Common buffer release
  // ************************************************************
  assign release_slot = (i_lmfc_count == i_cfg_buffer_delay) || i_cfg_buffer_early_release;

  always_ff @(posedge clk) begin
    if (i_device_reset) begin
      o_buffer_release_n <= 1'b1;
      o_rx_valid <= 1'b0;
    end else begin
      if (release_slot)
        o_buffer_release_n <= |(i_buffer_ready_n & ~i_cfg_lanes_disable);
      o_rx_valid <= !o_buffer_release_n;  // Matches the buffer read register
    end
  end

  // ************************************************************
  // Frame and multiframe markers
  // ************************************************************
  always_comb begin
    pos = frame_pos;
    for (int j = 0; j < `JRX_DPW; j++) begin
      sof_s[j] = (pos == 3'd0);
      eof_s[j] = (pos == i_cfg_octets_per_frame - 3'd1);
      pos = eof_s[j] ? 3'd0 : pos + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_device_reset || !o_rx_valid) begin
      mf_beat   <= '0;
      frame_pos <= '0;
    end else begin
      frame_pos <= pos;
      mf_beat <= (mf_beat >= i_cfg_beats_per_multiframe) ? '0 : mf_beat + 1'b1;
    end
  end

  assign o_rx_sof  = o_rx_valid ? sof_s : '0;
  assign o_rx_eof  = o_rx_valid ? eof_s : '0;
  assign o_rx_somf = {{(`JRX_DPW-1){1'b0}}, o_rx_valid && mf_beat == '0};
  assign o_rx_eomf = {o_rx_valid && mf_beat == i_cfg_beats_per_multiframe,
                      {(`JRX_DPW-1){1'b0}}};

endmodule

// ==== src/jrx_rx.sv ====
`timescale 1ns/100ps
`include "jrx_settings.svh"

module jrx_rx (
  input  logic                                           clk,
  input  logic                                           device_reset,
  input  jrx_link_pkg::beat_t       [`JRX_NUM_LANES-1:0] i_phy_data,
  input  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] i_phy_charisk,
  input  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] i_phy_notintable,
  input  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] i_phy_disperr,
  input  logic                                           i_sysref,
  input  jrx_link_pkg::lane_mask_t                       i_cfg_lanes_disable,
  input  jrx_link_pkg::lmfc_count_t                      i_cfg_beats_per_multiframe,
  input  logic [2:0]                                     i_cfg_octets_per_frame,
  input  jrx_link_pkg::lmfc_count_t                      i_cfg_lmfc_offset,
  input  logic                                           i_cfg_sysref_oneshot,
  input  jrx_link_pkg::lmfc_count_t                      i_cfg_buffer_delay,
  input  logic                                           i_cfg_buffer_early_release,
  output logic                                           o_sync,
  output jrx_link_pkg::beat_t       [`JRX_NUM_LANES-1:0] o_rx_data,
  output logic                                           o_rx_valid,
  output jrx_link_pkg::mark_t                            o_rx_sof,
  output jrx_link_pkg::mark_t                            o_rx_eof,
  output jrx_link_pkg::mark_t                            o_rx_somf,
  output jrx_link_pkg::mark_t                            o_rx_eomf,
  output logic                                           o_sysref_edge,
  output logic                                           o_sysref_alignment_error,
  output logic                                           o_event_unexpected_lane_state,
  output jrx_link_pkg::ctrl_state_t                      o_status_state,
  output jrx_lane_pkg::cgs_state_t  [`JRX_NUM_LANES-1:0] o_status_lane_cgs_state
);

  jrx_link_pkg::lane_mask_t  cgs_reset;
  jrx_link_pkg::lane_mask_t  cgs_ready;
  jrx_link_pkg::lane_mask_t  buffer_ready_n;
  jrx_link_pkg::lmfc_count_t lmfc_count;
  logic                      lmfc_edge;
  logic                      buffer_release_n;

  for (genvar i = 0; i < `JRX_NUM_LANES; i++) begin : gen_lane
    jrx_lane i_lane (
      .clk                (clk),
      .i_device_reset     (device_reset),
      .i_phy_data         (i_phy_data[i]),
      .i_phy_charisk      (i_phy_charisk[i]),
      .i_phy_notintable   (i_phy_notintable[i]),
      .i_phy_disperr      (i_phy_disperr[i]),
      .i_cgs_reset        (cgs_reset[i]),
      .i_buffer_release_n (buffer_release_n),
      .o_cgs_ready        (cgs_ready[i]),
      .o_buffer_ready_n   (buffer_ready_n[i]),
      .o_rx_data          (o_rx_data[i]),
      .o_cgs_state        (o_status_lane_cgs_state[i])
    );
  end

  jrx_link_ctrl i_link_ctrl (
    .clk                           (clk),
    .i_device_reset                (device_reset),
    .i_cfg_lanes_disable           (i_cfg_lanes_disable),
    .i_cgs_ready                   (cgs_ready),
    .i_lmfc_edge                   (lmfc_edge),
    .o_cgs_reset                   (cgs_reset),
    .o_sync                        (o_sync),
    .o_status_state                (o_status_state),
    .o_event_unexpected_lane_state (o_event_unexpected_lane_state)
  );

  jrx_lmfc i_lmfc (
    .clk                        (clk),
    .i_device_reset             (device_reset),
    .i_sysref                   (i_sysref),
    .i_cfg_beats_per_multiframe (i_cfg_beats_per_multiframe),
    .i_cfg_lmfc_offset          (i_cfg_lmfc_offset),
    .i_cfg_sysref_oneshot       (i_cfg_sysref_oneshot),
    .o_lmfc_edge                (lmfc_edge),
    .o_lmfc_count               (lmfc_count),
    .o_sysref_edge              (o_sysref_edge),
    .o_sysref_alignment_error   (o_sysref_alignment_error)
  );

  jrx_release_framer i_release_framer (
    .clk                        (clk),
    .i_device_reset             (device_reset),
    .i_lmfc_count               (lmfc_count),
    .i_cfg_buffer_delay         (i_cfg_buffer_delay),
    .i_cfg_buffer_early_release (i_cfg_buffer_early_release),
    .i_cfg_lanes_disable        (i_cfg_lanes_disable),
    .i_buffer_ready_n           (buffer_ready_n),
    .i_cfg_octets_per_frame     (i_cfg_octets_per_frame),
    .i_cfg_beats_per_multiframe (i_cfg_beats_per_multiframe),
    .o_buffer_release_n         (buffer_release_n),
    .o_rx_valid                 (o_rx_valid),
    .o_rx_sof                   (o_rx_sof),
    .o_rx_eof                   (o_rx_eof),
    .o_rx_somf                  (o_rx_somf),
    .o_rx_eomf                  (o_rx_eomf)
  );

endmodule

// ==== bench/jrx_rx_tb.sv ====
`timescale 1ns/100ps
`include "jrx_settings.svh"

module jrx_rx_tb;

  localparam int NUM_VALID       = 48;   // Beats checked per data test
  localparam int MF_BEATS        = 8;
  localparam int SYSREF_CYCLES   = 45;
  localparam int LINK_CYCLES     = NUM_VALID + 60;
  localparam int WATCHDOG_CYCLES = (SYSREF_CYCLES + 4 * LINK_CYCLES) * 40;

  logic                                           clk;
  logic                                           device_reset;
  jrx_link_pkg::beat_t       [`JRX_NUM_LANES-1:0] phy_data;
  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] phy_charisk;
  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] phy_notintable;
  jrx_lane_pkg::char_flags_t [`JRX_NUM_LANES-1:0] phy_disperr;
  logic                                           sysref;
  jrx_link_pkg::lane_mask_t                       cfg_lanes_disable;
  jrx_link_pkg::lmfc_count_t                      cfg_beats_per_multiframe;
  logic [2:0]                                     cfg_octets_per_frame;
  jrx_link_pkg::lmfc_count_t                      cfg_lmfc_offset;
  logic                                           cfg_sysref_oneshot;
  jrx_link_pkg::lmfc_count_t                      cfg_buffer_delay;
  logic                                           cfg_buffer_early_release;
  logic                                           sync;
  jrx_link_pkg::beat_t       [`JRX_NUM_LANES-1:0] rx_data;
  logic                                           rx_valid;
  jrx_link_pkg::mark_t                            rx_sof;
  jrx_link_pkg::mark_t                            rx_eof;
  jrx_link_pkg::mark_t                            rx_somf;
  jrx_link_pkg::mark_t                            rx_eomf;
  logic                                           sysref_edge;
  logic                                           sysref_alignment_error;
  logic                                           event_unexpected_lane_state;
  jrx_link_pkg::ctrl_state_t                      status_state;
  jrx_lane_pkg::cgs_state_t  [`JRX_NUM_LANES-1:0] lane_cgs_state;

  // Stimulus and scoreboard state
  jrx_link_pkg::beat_t lane_key [`JRX_NUM_LANES];
  int  skew_left [`JRX_NUM_LANES];
  int  idx [`JRX_NUM_LANES];
  int  err_left [`JRX_NUM_LANES];
  int  k_sent [`JRX_NUM_LANES];
  bit  data_on = 0;
  bit  checking = 0;
  int  valid_count = 0;
  int  rx_idx = 0;
  int  sysref_edges = 0;
  int  align_errors = 0;
  int  lane_events = 0;
  int  mismatches = 0;
  int  failures = 0;

  jrx_rx i_dut (
    .clk                           (clk),
    .device_reset                  (device_reset),
    .i_phy_data                    (phy_data),
    .i_phy_charisk                 (phy_charisk),
    .i_phy_notintable              (phy_notintable),
    .i_phy_disperr                 (phy_disperr),
    .i_sysref                      (sysref),
    .i_cfg_lanes_disable           (cfg_lanes_disable),
    .i_cfg_beats_per_multiframe    (cfg_beats_per_multiframe),
    .i_cfg_octets_per_frame        (cfg_octets_per_frame),
    .i_cfg_lmfc_offset             (cfg_lmfc_offset),
    .i_cfg_sysref_oneshot          (cfg_sysref_oneshot),
    .i_cfg_buffer_delay            (cfg_buffer_delay),
    .i_cfg_buffer_early_release    (cfg_buffer_early_release),
    .o_sync                        (sync),
    .o_rx_data                     (rx_data),
    .o_rx_valid                    (rx_valid),
    .o_rx_sof                      (rx_sof),
    .o_rx_eof                      (rx_eof),
    .o_rx_somf                     (rx_somf),
    .o_rx_eomf                     (rx_eomf),
    .o_sysref_edge                 (sysref_edge),
    .o_sysref_alignment_error      (sysref_alignment_error),
    .o_event_unexpected_lane_state (event_unexpected_lane_state),
    .o_status_state                (status_state),
    .o_status_lane_cgs_state       (lane_cgs_state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ************************************************************
  // Reference model
  // ************************************************************
  function automatic jrx_link_pkg::beat_t payload_beat(input int lane, input int n);
    return lane_key[lane] ^ (32'(n) * 32'h9e3779b9);
  endfunction

  // Returns {sof, eof, somf, eomf} for valid beat n
  function automatic logic [15:0] marker_bits(input int n, input int f, input int mf);
    jrx_link_pkg::mark_t sof;
    jrx_link_pkg::mark_t eof;
    jrx_link_pkg::mark_t somf;
    jrx_link_pkg::mark_t eomf;
    int k;
    somf = '0;
    eomf = '0;
    for (int j = 0; j < `JRX_DPW; j++) begin
      k = n * `JRX_DPW + j;               // Octets since the first valid beat
      sof[j] = (k % f == 0);
      eof[j] = (k % f == f - 1);
    end
    somf[0] = (n % mf == 0);
    eomf[`JRX_DPW-1] = (n % mf == mf - 1);
    return {sof, eof, somf, eomf};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      failures++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic check_lane_state(input int lane, input jrx_lane_pkg::cgs_state_t exp);
    compare_value($sformatf("o_status_lane_cgs_state[%0d]", lane), exp,
                  lane_cgs_state[lane]);
  endtask

  // ************************************************************
  // Lane stimulus, K characters until data starts after the skew
  // ************************************************************
  task automatic drive_lanes();
    for (int l = 0; l < `JRX_NUM_LANES; l++) begin
      if (!data_on || skew_left[l] > 0) begin
        phy_data[l] = {`JRX_DPW{`JRX_K28_5}};
        phy_charisk[l] = '1;
        k_sent[l]++;
        if (data_on)
          skew_left[l]--;
      end else begin
        phy_data[l] = payload_beat(l, idx[l]);
        phy_charisk[l] = '0;
        idx[l]++;
      end
      phy_disperr[l] = (err_left[l] > 0) ? '1 : '0;
      if (err_left[l] > 0)
        err_left[l]--;
    end
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      drive_lanes();
    end
  endtask

  task automatic apply_reset(input int f, input jrx_link_pkg::lane_mask_t mask);
    cfg_octets_per_frame = 3'(f);
    cfg_lanes_disable = mask;
    data_on = 0;
    for (int l = 0; l < `JRX_NUM_LANES; l++) begin
      idx[l] = 0;
      err_left[l] = 0;
      skew_left[l] = 0;
    end
    device_reset = 1'b1;
    step(3);
    compare_value("o_sync", 0, sync);
    compare_value("o_rx_valid", 0, rx_valid);
    compare_value("o_rx_sof", 0, rx_sof);
    compare_value("o_rx_eof", 0, rx_eof);
    compare_value("o_rx_somf", 0, rx_somf);
    compare_value("o_rx_eomf", 0, rx_eomf);
    compare_value("o_sysref_edge", 0, sysref_edge);
    compare_value("o_sysref_alignment_error", 0, sysref_alignment_error);
    compare_value("o_event_unexpected_lane_state", 0, event_unexpected_lane_state);
    compare_value("o_status_state", jrx_link_pkg::CTRL_RESET, status_state);
    for (int l = 0; l < `JRX_NUM_LANES; l++)
      check_lane_state(l, jrx_lane_pkg::CGS_INIT);
    device_reset = 1'b0;
    for (int l = 0; l < `JRX_NUM_LANES; l++)
      k_sent[l] = 0;
  endtask

  task automatic sysref_pulse(input int gap);
    sysref = 1'b1;
    step(1);
    sysref = 1'b0;
    step(gap - 1);
  endtask

  task automatic sysref_test();
    apply_reset(4, '0);
    sysref_edges = 0;
    align_errors = 0;
    step(1);
    sysref_pulse(2 * MF_BEATS);     // First edge aligns the LMFC
    sysref_pulse(2 * MF_BEATS + 3); // Second edge lands on phase
    compare_value("o_sysref_alignment_error pulses", 0, align_errors);
    sysref_pulse(MF_BEATS);         // Third edge is 3 beats off
    compare_value("o_sysref_edge pulses", 3, sysref_edges);
    compare_value("o_sysref_alignment_error pulses", 1, align_errors);
  endtask

  task automatic run_link(input int f, input jrx_link_pkg::lane_mask_t mask);
    int n;
    apply_reset(f, mask);
    for (int l = 0; l < `JRX_NUM_LANES; l++) begin
      lane_key[l] = $urandom();
      skew_left[l] = $urandom_range(5, 0);
    end
    n = 0;
    while (!sync && n < 100) begin
      step(1);
      n++;
    end
    expect_true(sync, "o_sync did not rise while /K/ was sent on all lanes");
    compare_value("o_status_state", jrx_link_pkg::CTRL_DATA, status_state);
    for (int l = 0; l < `JRX_NUM_LANES; l++)
      check_lane_state(l, mask[l] ? jrx_lane_pkg::CGS_INIT : jrx_lane_pkg::CGS_DATA);
    valid_count = 0;
    checking = 1;
    data_on = 1;
    n = 0;
    while (valid_count < NUM_VALID && n < LINK_CYCLES) begin
      step(1);
      n++;
    end
    expect_true(valid_count >= NUM_VALID, "too few valid beats after the frame start");
    checking = 0;
  endtask

  task automatic lane_dropout(input bit expect_event);
    lane_events = 0;
    err_left[1] = `JRX_CGS_ERR_BEATS;
    step(`JRX_CGS_ERR_BEATS + 5);
    compare_value("o_event_unexpected_lane_state pulses", expect_event, lane_events);
    compare_value("o_sync", !expect_event, sync);
    compare_value("o_status_state",
                  expect_event ? jrx_link_pkg::CTRL_CGS : jrx_link_pkg::CTRL_DATA,
                  status_state);
    check_lane_state(0, jrx_lane_pkg::CGS_DATA);
    check_lane_state(1, jrx_lane_pkg::CGS_INIT);
  endtask

  // Pulse counters and the link-up rule
  initial begin
    forever begin
      @(negedge clk);
      if (sysref_edge)
        sysref_edges++;
      if (sysref_alignment_error)
        align_errors++;
      if (event_unexpected_lane_state)
        lane_events++;
      if (sync)
        expect_true(k_sent[0] >= `JRX_CGS_K_BEATS && k_sent[1] >= `JRX_CGS_K_BEATS,
                    "o_sync high before every lane sent enough /K/ beats");
    end
  end

  initial begin : compare_beats
    logic [15:0] marks;
    forever begin
      @(negedge clk);
      if (!rx_valid) begin
        rx_idx = 0;
      end else begin
        if (checking) begin
          marks = marker_bits(rx_idx, cfg_octets_per_frame, MF_BEATS);
          for (int l = 0; l < `JRX_NUM_LANES; l++) begin
            if (!cfg_lanes_disable[l])
              compare_value($sformatf("o_rx_data[%0d]", l), payload_beat(l, rx_idx),
                            rx_data[l]);
          end
          compare_value("o_rx_sof", marks[15:12], rx_sof);
          compare_value("o_rx_eof", marks[11:8], rx_eof);
          compare_value("o_rx_somf", marks[7:4], rx_somf);
          compare_value("o_rx_eomf", marks[3:0], rx_eomf);
          valid_count++;
        end
        rx_idx++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial begin
    void'($urandom(30));
    device_reset = 1'b1;
    phy_data = '0;
    phy_charisk = '0;
    phy_notintable = '0;
    phy_disperr = '0;
    sysref = 1'b0;
    cfg_lanes_disable = '0;
    cfg_beats_per_multiframe = 8'(MF_BEATS - 1);
    cfg_octets_per_frame = 3'd4;
    cfg_lmfc_offset = '0;
    cfg_sysref_oneshot = 1'b0;
    cfg_buffer_delay = 8'd3;
    cfg_buffer_early_release = 1'b0;

    sysref_test();
    run_link(1, 2'b00);
    run_link(2, 2'b00);
    run_link(4, 2'b00);
    lane_dropout(1);
    run_link(2, 2'b10);  // Lane 1 disabled
    lane_dropout(0);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/jrx_link_pkg.sv
src/jrx_lane_pkg.sv
src/jrx_lane.sv
src/jrx_link_ctrl.sv
src/jrx_lmfc.sv
src/jrx_release_framer.sv
src/jrx_rx.sv
bench/jrx_rx_tb.sv
